//--- source/vic_pkg.sv
package vic_pkg;

   // chip variants, NTSC old/new and PAL
   typedef enum logic [1:0] {
      CHIP_6567R8   = 2'd0,
      CHIP_6567R56A = 2'd1,
      CHIP_6569     = 2'd2
   } chip_e;

   // beam counter widths
   localparam int RASTER_X_W = 10;
   localparam int RASTER_Y_W = 9;

   // dot4x cycles per phi half
   localparam int PHI_HALF = 16;

   // cpu visible register addresses
   localparam logic [5:0] REG_CTRL1  = 6'h11;
   localparam logic [5:0] REG_RASTER = 6'h12;
   localparam logic [5:0] REG_IRQ    = 6'h19;
   localparam logic [5:0] REG_IRQ_EN = 6'h1A;

   // lines where a badline may occur
   localparam logic [RASTER_Y_W-1:0] BADLINE_FIRST = 9'd48;
   localparam logic [RASTER_Y_W-1:0] BADLINE_LAST  = 9'd247;

   // cycles with ba low on a badline, three ahead of the first c-access
   localparam logic [RASTER_X_W-4:0] BA_CYCLE_FIRST = 7'd12;
   localparam logic [RASTER_X_W-4:0] BA_CYCLE_LAST  = 7'd54;

   typedef struct packed {
      logic [RASTER_X_W-1:0] raster_x_max;
      logic [RASTER_Y_W-1:0] raster_y_max;
   } chip_limits_t;

   // last pixel of a line and last line of a frame per chip
   function automatic chip_limits_t chip_limits(input chip_e chip);
      chip_limits_t lim;
      case (chip)
         // 520 pixels, 263 lines
         CHIP_6567R8:   lim = '{raster_x_max: 10'd519, raster_y_max: 9'd262};
         // 512 pixels, 262 lines
         CHIP_6567R56A: lim = '{raster_x_max: 10'd511, raster_y_max: 9'd261};
         // 504 pixels, 312 lines
         default:       lim = '{raster_x_max: 10'd503, raster_y_max: 9'd311};
      endcase
      return lim;
   endfunction

endpackage

//--- source/vic_beam_if.sv
`timescale 1ns/1ps

interface vic_beam_if import vic_pkg::*; ();

   // phase strobes from the clock generator
   logic clk_phi;
   logic dot_tick;
   logic phi_last;

   // beam position from the raster counters
   logic [RASTER_X_W-1:0] raster_x;
   logic [RASTER_Y_W-1:0] raster_line;
   logic                  line_start;
   // 8 pixels per cycle
   logic [RASTER_X_W-4:0] cycle_num;

   modport clocks (output clk_phi, dot_tick, phi_last);

   modport beam (input clk_phi, dot_tick, phi_last,
                 output raster_x, raster_line, line_start, cycle_num);

   modport user (input clk_phi, dot_tick, phi_last,
                 raster_x, raster_line, line_start, cycle_num);

endinterface

//--- source/vic_clocks.sv
`timescale 1ns/1ps

module vic_clocks import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       rst,
   vic_beam_if.clocks beam
);

   // one full phi period, msb is the live phi level
   logic [2*PHI_HALF-1:0] phi_ring;
   // one dot period, msb marks the dot tick
   logic [3:0]            dot_ring;

   // phi starts low for a full half after reset
   // dot ring is lined up so a tick lands on the last cycle of each phi half
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring <= {{PHI_HALF{1'b0}}, {PHI_HALF{1'b1}}};
         dot_ring <= 4'b0001;
      end else begin
         phi_ring <= {phi_ring[2*PHI_HALF-2:0], phi_ring[2*PHI_HALF-1]};
         dot_ring <= {dot_ring[2:0], dot_ring[3]};
      end
   end

   assign beam.clk_phi  = phi_ring[2*PHI_HALF-1];

   // next bit differs, so phi toggles on the coming edge
   assign beam.phi_last = phi_ring[2*PHI_HALF-1] ^ phi_ring[2*PHI_HALF-2];

   // once every four dot4x cycles
   assign beam.dot_tick = dot_ring[3];

   // phi may only move right after the boundary strobe
   a_phi_on_boundary : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      $changed(beam.clk_phi) |-> $past(beam.phi_last)
   ) else $error("clk_phi toggled away from a phase boundary at %0t", $time);

endmodule

//--- source/vic_raster.sv
`timescale 1ns/1ps

module vic_raster import vic_pkg::*; #(
   parameter chip_e CHIP = CHIP_6569
) (
   input  logic     clk_dot4x,
   input  logic     rst,
   vic_beam_if.beam beam
);

   // limits of the selected chip
   localparam chip_limits_t LIM = chip_limits(CHIP);

   logic [RASTER_X_W-1:0] raster_x;
   logic [RASTER_Y_W-1:0] raster_line;
   logic                  line_start;
   logic                  x_at_max;
   logic                  y_at_max;

   assign x_at_max = (raster_x == LIM.raster_x_max);
   assign y_at_max = (raster_line == LIM.raster_y_max);

   // x steps once per dot
   // line steps when x wraps, frame wraps after the last line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         raster_x    <= '0;
         raster_line <= '0;
         line_start  <= 1'b0;
      end else begin
         line_start <= 1'b0;
         if (beam.dot_tick) begin
            if (x_at_max) begin
               raster_x   <= '0;
               line_start <= 1'b1;
               if (y_at_max) begin
                  raster_line <= '0;
               end else begin
                  raster_line <= raster_line + 1'b1;
               end
            end else begin
               raster_x <= raster_x + 1'b1;
            end
         end
      end
   end

   assign beam.raster_x    = raster_x;
   assign beam.raster_line = raster_line;
   assign beam.line_start  = line_start;
   // divide by 8
   assign beam.cycle_num   = raster_x[RASTER_X_W-1:3];

   // counter must stay within the chip's line length
   a_x_in_range : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      raster_x <= LIM.raster_x_max
   ) else $error("raster_x %0d past chip limit at %0t", raster_x, $time);

endmodule

//--- source/vic_registers.sv
`timescale 1ns/1ps

module vic_registers import vic_pkg::*; (
   input  logic        clk_dot4x,
   input  logic        rst,
   vic_beam_if.user    beam,
   input  logic        ce_i,
   input  logic        rw_i,
   input  logic [5:0]  adi_i,
   input  logic [7:0]  dbi_i,
   output logic [7:0]  dbo_o,
   output logic        den_o,
   output logic [2:0]  yscroll_o,
   output logic        irq_o
);

   // control register 1 fields
   logic [2:0]            yscroll;
   logic                  den;
   // raster compare, bit 8 lives in ctrl1 bit 7
   logic [RASTER_Y_W-1:0] raster_cmp;

   // raster irq latch and its enable
   logic irst;
   logic erst;
   logic irst_d;
   logic erst_d;

   logic       reg_wr;
   logic [7:0] rd_data;

   // cpu write strobe, end of phi high with chip selected
   assign reg_wr = beam.clk_phi && beam.phi_last && !ce_i && !rw_i;

   // next latch state
   // line match wins over a clear in the same cycle
   always_comb begin
      irst_d = irst;
      erst_d = erst;
      if (reg_wr && adi_i == REG_IRQ && dbi_i[0]) begin
         irst_d = 1'b0;
      end
      if (beam.line_start && beam.raster_line == raster_cmp) begin
         irst_d = 1'b1;
      end
      if (reg_wr && adi_i == REG_IRQ_EN) begin
         erst_d = dbi_i[0];
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         yscroll    <= '0;
         den        <= 1'b0;
         raster_cmp <= '0;
         irst       <= 1'b0;
         erst       <= 1'b0;
         irq_o      <= 1'b0;
      end else begin
         if (reg_wr) begin
            case (adi_i)
               REG_CTRL1: begin
                  yscroll                  <= dbi_i[2:0];
                  den                      <= dbi_i[4];
                  raster_cmp[RASTER_Y_W-1] <= dbi_i[7];
               end
               REG_RASTER: raster_cmp[7:0] <= dbi_i;
               default: ;
            endcase
         end
         irst  <= irst_d;
         erst  <= erst_d;
         // irq trails the latch and its enable by one cycle
         irq_o <= irst & erst;
      end
   end

   // read mux, unused irq bits read high
   always_comb begin
      case (adi_i)
         REG_CTRL1:  rd_data = {beam.raster_line[RASTER_Y_W-1], 2'b00, den, 1'b0, yscroll};
         REG_RASTER: rd_data = beam.raster_line[7:0];
         REG_IRQ:    rd_data = {irq_o, 3'b111, 3'b000, irst};
         REG_IRQ_EN: rd_data = {4'hF, 3'b000, erst};
         default:    rd_data = 8'hFF;
      endcase
   end

   // bus floats high when not selected
   assign dbo_o     = ce_i ? 8'hFF : rd_data;
   assign den_o     = den;
   assign yscroll_o = yscroll;

   // irq outlives irst only for the cycle after a clear
   a_irq_has_source : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      (irq_o && !irst) |-> $past(reg_wr && adi_i == REG_IRQ && dbi_i[0])
   ) else $error("irq high without a latched raster match at %0t", $time);

endmodule

//--- source/vic_bus_arbiter.sv
`timescale 1ns/1ps

module vic_bus_arbiter import vic_pkg::*; (
   input  logic       clk_dot4x,
   input  logic       rst,
   vic_beam_if.user   beam,
   input  logic       den_i,
   input  logic [2:0] yscroll_i,
   input  logic       ce_i,
   input  logic       rw_i,
   output logic       ba_o,
   output logic       aec_o,
   output logic       vic_write_db_o,
   output logic       ls245_data_dir_o
);

   logic allow_bad_lines;
   logic badline;
   logic ba_window;
   // last cycle of phi low, phi rises next
   logic phi_rise_next;
   // ba history over the last three phi-high starts
   logic ba1;
   logic ba2;
   logic ba3;

   assign phi_rise_next = !beam.clk_phi && beam.phi_last;

   // den only counts at the top of line 48
   // window closes after the last possible badline
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         allow_bad_lines <= 1'b0;
      end else if (beam.line_start) begin
         if (beam.raster_line == BADLINE_FIRST && den_i) begin
            allow_bad_lines <= 1'b1;
         end
         if (beam.raster_line == BADLINE_LAST + 1'b1) begin
            allow_bad_lines <= 1'b0;
         end
      end
   end

   assign badline = allow_bad_lines
                    && beam.raster_line >= BADLINE_FIRST
                    && beam.raster_line <= BADLINE_LAST
                    && beam.raster_line[2:0] == yscroll_i;

   assign ba_window = beam.cycle_num >= BA_CYCLE_FIRST && beam.cycle_num <= BA_CYCLE_LAST;

   // active low bus request for the c-accesses
   assign ba_o = !(badline && ba_window);

   // cpu gets three more phi-high cycles after ba falls
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba1 <= 1'b1;
         ba2 <= 1'b1;
         ba3 <= 1'b1;
      end else if (phi_rise_next) begin
         ba1 <= ba_o;
         ba2 <= ba1 | ba_o;
         ba3 <= ba2 | ba_o;
      end
   end

   // aec tracks phi one cycle late, held low once the cascade runs out
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         aec_o <= 1'b0;
      end else begin
         aec_o <= ba_o ? beam.clk_phi : (ba3 & beam.clk_phi);
      end
   end

   // drive the data bus only on a cpu read of our registers
   assign vic_write_db_o   = aec_o && rw_i && !ce_i;
   assign ls245_data_dir_o = !vic_write_db_o;

   // cpu held off in phi high only during a badline steal
   a_steal_on_badline : assert property (
      @(posedge clk_dot4x) disable iff (rst)
      (beam.clk_phi && $past(beam.clk_phi) && !aec_o) |-> (!ba_o && badline)
   ) else $error("aec held low outside a badline at %0t", $time);

endmodule

//--- source/vic_core.sv
`timescale 1ns/1ps

module vic_core import vic_pkg::*; #(
   parameter chip_e CHIP = CHIP_6569
) (
   input  logic                  clk_dot4x,
   input  logic                  rst,
   input  logic                  ce_i,
   input  logic                  rw_i,
   input  logic [5:0]            adi_i,
   input  logic [7:0]            dbi_i,
   output logic [7:0]            dbo_o,
   output logic                  clk_phi_o,
   output logic [RASTER_X_W-1:0] raster_x_o,
   output logic [RASTER_Y_W-1:0] raster_line_o,
   output logic                  irq_o,
   output logic                  ba_o,
   output logic                  aec_o,
   output logic                  vic_write_db_o,
   output logic                  ls245_data_dir_o
);

   vic_beam_if beam ();

   // ctrl1 fields feeding the badline rule
   logic       den;
   logic [2:0] yscroll;

   vic_clocks i_clocks (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .beam      (beam.clocks)
   );

   vic_raster #(.CHIP(CHIP)) i_raster (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .beam      (beam.beam)
   );

   vic_registers i_registers (
      .clk_dot4x (clk_dot4x), .rst (rst), .beam (beam.user),
      .ce_i (ce_i), .rw_i (rw_i), .adi_i (adi_i), .dbi_i (dbi_i), .dbo_o (dbo_o),
      .den_o (den), .yscroll_o (yscroll), .irq_o (irq_o)
   );

   vic_bus_arbiter i_bus_arbiter (
      .clk_dot4x (clk_dot4x), .rst (rst), .beam (beam.user),
      .den_i (den), .yscroll_i (yscroll), .ce_i (ce_i), .rw_i (rw_i),
      .ba_o (ba_o), .aec_o (aec_o),
      .vic_write_db_o (vic_write_db_o), .ls245_data_dir_o (ls245_data_dir_o)
   );

   assign clk_phi_o     = beam.clk_phi;
   assign raster_x_o    = beam.raster_x;
   assign raster_line_o = beam.raster_line;

endmodule

//--- tests/tb_vic_core.sv
`timescale 1ns/1ps

module tb_vic_core import vic_pkg::*; ();

   // pal line and frame, 504 pixels by 312 lines
   localparam int unsigned LINE_CYCLES    = 2016;
   localparam int unsigned X_PIXELS       = 504;
   localparam int unsigned FRAME_LINES    = 312;
   // about 70 lines of 2016 cycles plus margin
   localparam int unsigned TIMEOUT_CYCLES = 160_000;

   logic                  clk_dot4x;
   logic                  rst;
   logic                  ce_i;
   logic                  rw_i;
   logic [5:0]            adi_i;
   logic [7:0]            dbi_i;
   logic [7:0]            dbo_o;
   logic                  clk_phi_o;
   logic [RASTER_X_W-1:0] raster_x_o;
   logic [RASTER_Y_W-1:0] raster_line_o;
   logic                  irq_o;
   logic                  ba_o;
   logic                  aec_o;
   logic                  vic_write_db_o;
   logic                  ls245_data_dir_o;

   // reference beam, counted in dot4x cycles from reset release
   int unsigned           k;
   logic [RASTER_X_W-1:0] exp_x;
   logic [RASTER_Y_W-1:0] exp_line;
   logic [RASTER_X_W-4:0] exp_cyc;
   logic                  exp_phi;
   logic                  exp_ba;
   logic                  exp_aec;
   logic                  exp_irq;
   // phi-high starts in a row with ba low, saturates at 3
   logic [1:0]            ba_run;
   logic                  wr_edge;
   // register shadow and irq latch model
   logic [2:0]            ysc_w;
   logic                  den_w;
   logic [8:0]            cmp_w;
   logic                  irst_m;
   logic                  erst_m;
   logic [7:0]            lfsr;
   // wrap, irq, masked match, steal, db drive
   logic [4:0]            reached;

   vic_core #(.CHIP(CHIP_6569)) i_dut (.*);

   initial begin
      clk_dot4x = 1'b0;
      forever #10 clk_dot4x = ~clk_dot4x;
   end

   assign exp_x    = 10'((k / 4) % X_PIXELS);
   assign exp_line = 9'((k / LINE_CYCLES) % FRAME_LINES);
   assign exp_cyc  = exp_x[RASTER_X_W-1:3];
   assign exp_phi  = (k % (2 * PHI_HALF)) >= PHI_HALF;
   assign exp_ba   = !(den_w && exp_line >= BADLINE_FIRST && exp_line <= BADLINE_LAST
                       && exp_line[2:0] == ysc_w
                       && exp_cyc >= BA_CYCLE_FIRST && exp_cyc <= BA_CYCLE_LAST);
   // cpu write lands on the last cycle of phi high
   assign wr_edge  = exp_phi && (k % PHI_HALF) == PHI_HALF - 1 && !ce_i && !rw_i;

   always @(posedge clk_dot4x) begin
      if (rst) begin
         k       <= 0;
         exp_aec <= 1'b0;
         exp_irq <= 1'b0;
         ba_run  <= 2'd0;
         irst_m  <= 1'b0;
         erst_m  <= 1'b0;
         ysc_w   <= 3'd0;
         den_w   <= 1'b0;
         cmp_w   <= 9'd0;
         reached <= 5'd0;
      end else begin
         k <= k + 1;
         // sample ba just before phi rises
         if (!exp_phi && (k % PHI_HALF) == PHI_HALF - 1) begin
            ba_run <= exp_ba ? 2'd0 : (ba_run == 2'd3 ? 2'd3 : ba_run + 2'd1);
         end
         exp_aec <= exp_phi && !(ba_run == 2'd3 && !exp_ba);
         // irq comes one cycle after latch and enable
         exp_irq <= irst_m && erst_m;
         // match at line start wins over a clear
         if (k % LINE_CYCLES == 0 && k != 0 && exp_line == cmp_w) begin
            irst_m <= 1'b1;
         end else if (wr_edge && adi_i == REG_IRQ && dbi_i[0]) begin
            irst_m <= 1'b0;
         end
         if (wr_edge) begin
            case (adi_i)
               REG_CTRL1: begin
                  ysc_w    <= dbi_i[2:0];
                  den_w    <= dbi_i[4];
                  cmp_w[8] <= dbi_i[7];
               end
               REG_RASTER: cmp_w[7:0] <= dbi_i;
               REG_IRQ_EN: erst_m <= dbi_i[0];
               default: ;
            endcase
         end
         if (exp_x == 10'd503) reached[0] <= 1'b1;
         if (irq_o) reached[1] <= 1'b1;
         if (irst_m && !erst_m) reached[2] <= 1'b1;
         if (exp_phi && ba_run == 2'd3 && !exp_ba) reached[3] <= 1'b1;
         if (vic_write_db_o) reached[4] <= 1'b1;
         if (k >= TIMEOUT_CYCLES) abort_run("timeout, the run did not reach its end in time");
      end
   end

   a_phi : assert property (@(posedge clk_dot4x) disable iff (rst) clk_phi_o == exp_phi)
      else abort_run($sformatf("ERROR at %0t: clk_phi_o off the 32 cycle period", $time));
   a_beam : assert property (@(posedge clk_dot4x) disable iff (rst)
      raster_x_o == exp_x && raster_line_o == exp_line)
      else abort_run($sformatf("ERROR at %0t: beam position differs from model", $time));
   a_rd_raster : assert property (@(posedge clk_dot4x) disable iff (rst)
      (!ce_i && rw_i && adi_i == REG_RASTER) |-> dbo_o == exp_line[7:0])
      else abort_run($sformatf("ERROR at %0t: raster read wrong", $time));
   a_rd_ctrl1 : assert property (@(posedge clk_dot4x) disable iff (rst)
      (!ce_i && rw_i && adi_i == REG_CTRL1) |->
      (dbo_o[7] == exp_line[8] && dbo_o[4] == den_w && dbo_o[2:0] == ysc_w))
      else abort_run($sformatf("ERROR at %0t: ctrl1 read wrong", $time));
   a_rd_irq : assert property (@(posedge clk_dot4x) disable iff (rst)
      (!ce_i && rw_i && adi_i == REG_IRQ) |->
      (dbo_o[0] == irst_m && dbo_o[7] == exp_irq))
      else abort_run($sformatf("ERROR at %0t: irq status read wrong", $time));
   a_irq : assert property (@(posedge clk_dot4x) disable iff (rst) irq_o == exp_irq)
      else abort_run($sformatf("ERROR at %0t: irq_o differs from latch model", $time));
   a_ba : assert property (@(posedge clk_dot4x) disable iff (rst) ba_o == exp_ba)
      else abort_run($sformatf("ERROR at %0t: ba_o differs from badline model", $time));
   a_aec : assert property (@(posedge clk_dot4x) disable iff (rst) aec_o == exp_aec)
      else abort_run($sformatf("ERROR at %0t: aec_o differs from model", $time));
   a_db_dir : assert property (@(posedge clk_dot4x) disable iff (rst)
      vic_write_db_o == (exp_aec && rw_i && !ce_i) && ls245_data_dir_o == !vic_write_db_o)
      else abort_run($sformatf("ERROR at %0t: data bus direction wrong", $time));

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   // galois form, taps for x^8+x^6+x^5+x^4+1
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [7:0] value);
      value = 8'd0;
      for (int i = 0; i < n; i++) begin
         value = {value[6:0], lfsr[0]};
         lfsr  = lfsr_next(lfsr);
      end
   endtask

   // falling edge just before the posedge that sees the given phase
   task automatic wait_phase(input int unsigned phase);
      @(negedge clk_dot4x);
      while ((k % (2 * PHI_HALF)) != phase) @(negedge clk_dot4x);
   endtask

   task automatic cpu_write(input logic [5:0] addr, input logic [7:0] data);
      wait_phase(2 * PHI_HALF - 1);
      ce_i  = 1'b0;
      rw_i  = 1'b0;
      adi_i = addr;
      dbi_i = data;
      @(negedge clk_dot4x);
      ce_i = 1'b1;
      rw_i = 1'b1;
   endtask

   // one cycle read inside phi high
   task automatic cpu_read(input logic [5:0] addr);
      wait_phase(PHI_HALF + 4);
      ce_i  = 1'b0;
      adi_i = addr;
      @(negedge clk_dot4x);
      ce_i = 1'b1;
   endtask

   task automatic wait_line(input logic [8:0] line);
      while (raster_line_o != line) @(negedge clk_dot4x);
   endtask

   task automatic wait_irq();
      while (!irq_o) @(negedge clk_dot4x);
   endtask

   initial begin
      logic [7:0] cmp_draw;
      logic [7:0] ysc_draw;
      logic [8:0] cmp_a;
      logic [8:0] cmp_b;
      rst   = 1'b1;
      ce_i  = 1'b1;
      rw_i  = 1'b1;
      adi_i = 6'd0;
      dbi_i = 8'd0;
      lfsr  = 8'd23;
      repeat (4) @(negedge clk_dot4x);
      rst = 1'b0;
      draw_bits(3, cmp_draw);
      draw_bits(3, ysc_draw);
      cmp_a = 9'd2 + 9'(cmp_draw);
      cmp_b = cmp_a + 9'd10;
      // den on, compare bit 8 clear
      cpu_write(REG_CTRL1, {3'b000, 1'b1, 1'b0, ysc_draw[2:0]});
      cpu_write(REG_RASTER, cmp_a[7:0]);
      cpu_write(REG_IRQ_EN, 8'h01);
      cpu_read(REG_CTRL1);
      cpu_read(REG_RASTER);
      wait_irq();
      cpu_read(REG_IRQ);
      cpu_write(REG_IRQ, 8'h01);
      cpu_read(REG_IRQ);
      // masked match, then late enable
      cpu_write(REG_IRQ_EN, 8'h00);
      cpu_write(REG_RASTER, cmp_b[7:0]);
      wait_line(cmp_b + 9'd1);
      cpu_read(REG_IRQ);
      cpu_write(REG_IRQ_EN, 8'h01);
      wait_irq();
      cpu_read(REG_IRQ);
      cpu_write(REG_IRQ, 8'h01);
      // keep reading through the badline region, steals included
      while (raster_line_o != 9'd70) cpu_read(REG_RASTER);
      if (reached == 5'b11111) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         abort_run($sformatf("run ended with checks not reached, mask %b", reached));
      end
   end

endmodule

//--- sim.f
source/vic_pkg.sv
source/vic_beam_if.sv
source/vic_clocks.sv
source/vic_raster.sv
source/vic_registers.sv
source/vic_bus_arbiter.sv
source/vic_core.sv
tests/tb_vic_core.sv

//--- Makefile
# Verilator build and run for the vic timing core

VERILATOR  ?= verilator
TOP        ?= tb_vic_core
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
